//--- Makefile
# Verilator build and run of the VGA title-screen testbench
# Any variable can be overridden, e.g. make test BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= title_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
JOBS      ?= 0
VFLAGS    ?= --binary --assert --timescale $(TIMESCALE) -j $(JOBS)
SIM       ?= $(BUILD_DIR)/V$(TOP)

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR TIMESCALE JOBS VFLAGS"

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulation is the test result
test: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

//--- bench/title_tb.sv
module title_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import title_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	// Frame start right after reset and two full frames after it
	localparam int VSYNC_FALLS = 3;
	localparam int FALL_TIMEOUT = FRAME_CYCLES + 2 * H_TOTAL;
	// Pixel classes
	// Lit and cut-out codes carry the row as an offset
	localparam int CLS_NONE = 0;
	localparam int CLS_LIT = 1;
	localparam int CLS_CUT = 4;

	logic dclk;
	logic clr;
	logic hsync;
	logic vsync;
	logic [COLOUR_W-1:0] colour;

	// Position rebuilt from the sync outputs
	logic prev_hs;
	logic prev_vs;
	logic hs_seen;
	logic vs_seen;
	logic clr_q = 1'b1;
	int col_q;
	int line_q;
	int fcyc_q;
	// Rows that showed a lit and a cut-out pixel this frame
	logic [NUM_ROWS-1:0] lit_seen;
	logic [NUM_ROWS-1:0] cut_seen;

	logic hs_fall;
	logic vs_fall;
	int cur_col;
	int cur_line;
	logic in_window;
	int cls;
	logic [COLOUR_W-1:0] exp_colour;

	always #20 dclk = ~dclk;

	vga_title_top vga_title_top_inst (
		.dclk(dclk),
		.clr(clr),
		.hsync(hsync),
		.vsync(vsync),
		.colour(colour)
	);

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	// Half-open box test on a rectangle word {x_lo, x_hi, y_lo, y_hi}
	function automatic logic box_holds(input logic [RECT_W-1:0] r, input int x, input int y);
		int x_lo;
		int x_hi;
		int y_lo;
		int y_hi;
		x_lo = int'(r[4*CNT_W-1 -: CNT_W]);
		x_hi = int'(r[3*CNT_W-1 -: CNT_W]);
		y_lo = int'(r[2*CNT_W-1 -: CNT_W]);
		y_hi = int'(r[CNT_W-1 -: CNT_W]);
		return (x >= x_lo) && (x < x_hi) && (y >= y_lo) && (y < y_hi);
	endfunction

	// First lit row wins, else the first row whose cut-out holds the pixel
	function automatic int classify(input int x, input int y);
		int lit_code;
		int cut_code;
		logic in_cut;
		lit_code = CLS_NONE;
		cut_code = CLS_NONE;
		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int g = 0; g < NUM_GLYPHS; g++) begin
				if (int'(GLYPH_ROW[g]) == r && box_holds(GLYPH_BOX[g], x, y)) begin
					in_cut = 1'b0;
					for (int c = 0; c < NUM_CUTS; c++) begin
						if (int'(CUT_GLYPH[c]) == g && box_holds(CUT_RECT[c], x, y))
							in_cut = 1'b1;
					end
					if (!in_cut && lit_code == CLS_NONE)
						lit_code = CLS_LIT + r;
					else if (in_cut && cut_code == CLS_NONE)
						cut_code = CLS_CUT + r;
				end
			end
		end
		return (lit_code != CLS_NONE) ? lit_code : cut_code;
	endfunction

	// Column zero is the sample where hsync falls
	assign hs_fall = prev_hs && !hsync;
	assign vs_fall = prev_vs && !vsync;
	assign cur_col = hs_fall ? 0 : col_q + 1;
	assign cur_line = vs_fall ? 0 : (hs_fall ? line_q + 1 : line_q);
	assign in_window = (cur_col >= H_BP) && (cur_col < H_FP) &&
		(cur_line >= V_BP) && (cur_line < V_FP);

	always_comb begin
		cls = in_window ? classify(cur_col - H_BP, cur_line - V_BP) : CLS_NONE;
		exp_colour = COLOUR_BLACK;
		for (int r = 0; r < NUM_ROWS; r++) begin
			if (cls == CLS_LIT + r)
				exp_colour = ROW_COLOUR[r];
		end
	end

	// Tracker reads the sample that is ending on this edge
	always @(posedge dclk) begin
		clr_q <= clr;
		if (clr) begin
			prev_hs <= 1'b1;
			prev_vs <= 1'b1;
			hs_seen <= 1'b0;
			vs_seen <= 1'b0;
			col_q <= 0;
			line_q <= 0;
			fcyc_q <= 0;
			lit_seen <= '0;
			cut_seen <= '0;
		end else begin
			prev_hs <= hsync;
			prev_vs <= vsync;
			col_q <= cur_col;
			line_q <= cur_line;
			fcyc_q <= vs_fall ? 0 : fcyc_q + 1;
			if (hs_fall)
				hs_seen <= 1'b1;
			if (vs_fall)
				vs_seen <= 1'b1;
			// Coverage restarts with each frame
			if (vs_fall) begin
				lit_seen <= '0;
				cut_seen <= '0;
			end else begin
				for (int r = 0; r < NUM_ROWS; r++) begin
					if (cls == CLS_LIT + r)
						lit_seen[r] <= 1'b1;
					if (cls == CLS_CUT + r)
						cut_seen[r] <= 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks on the falling edge of dclk
	////////////////////////////////////////////////////////////////////////////

	task automatic report_value(input string name, input int got, input int exp);
		$display("FAIL t=%0t %s got 'h%0h expected 'h%0h", $time, name, got, exp);
		$display("tests failed");
		$fatal(1, "value mismatch");
	endtask

	task automatic report_text(input string what);
		$display("t=%0t %s", $time, what);
		$display("tests failed");
		$fatal(1, "check failed");
	endtask

	// Reset values hold through the edge that releases clr
	a_rst_hsync: assert property (@(negedge dclk) (clr || clr_q) |-> hsync)
		else report_value("hsync", int'(hsync), 1);
	a_rst_vsync: assert property (@(negedge dclk) (clr || clr_q) |-> vsync)
		else report_value("vsync", int'(vsync), 1);
	a_rst_colour: assert property (@(negedge dclk) (clr || clr_q) |-> colour == COLOUR_BLACK)
		else report_value("colour", int'(colour), int'(COLOUR_BLACK));

	// Falls exactly one line apart and stays low for the pulse width
	a_h_period: assert property (@(negedge dclk) disable iff (clr)
		hs_seen |-> (hs_fall == (col_q == H_TOTAL - 1)))
		else report_value("hsync falling edge", int'(hs_fall), int'(col_q == H_TOTAL - 1));
	a_h_pulse: assert property (@(negedge dclk) disable iff (clr)
		hs_seen |-> (hsync == (cur_col >= H_PULSE)))
		else report_value("hsync", int'(hsync), int'(cur_col >= H_PULSE));

	a_v_period: assert property (@(negedge dclk) disable iff (clr)
		vs_seen |-> (vs_fall == (fcyc_q == FRAME_CYCLES - 1)))
		else report_value("vsync falling edge", int'(vs_fall),
			int'(fcyc_q == FRAME_CYCLES - 1));
	a_v_pulse: assert property (@(negedge dclk) disable iff (clr)
		vs_seen |-> (vsync == (cur_line >= V_PULSE)))
		else report_value("vsync", int'(vsync), int'(cur_line >= V_PULSE));

	// Porches and off-screen lines
	a_blank: assert property (@(negedge dclk) disable iff (clr)
		(hs_seen && vs_seen && !in_window) |-> colour == COLOUR_BLACK)
		else report_value("colour", int'(colour), int'(COLOUR_BLACK));

	// Glyph bodies in their row colour
	a_glyph_lit: assert property (@(negedge dclk) disable iff (clr)
		(hs_seen && vs_seen && cls >= CLS_LIT && cls < CLS_CUT) |-> colour == exp_colour)
		else report_value("colour", int'(colour), int'(exp_colour));

	// Cut-outs and background
	a_glyph_dark: assert property (@(negedge dclk) disable iff (clr)
		(hs_seen && vs_seen && in_window && (cls == CLS_NONE || cls >= CLS_CUT))
		|-> colour == COLOUR_BLACK)
		else report_value("colour", int'(colour), int'(COLOUR_BLACK));

	// Every row drawn and punched at least once per full frame
	a_rows_reached: assert property (@(negedge dclk) disable iff (clr)
		(vs_fall && vs_seen) |-> (&lit_seen && &cut_seen))
		else report_text("a glyph row showed no lit pixel or no cut-out pixel in a frame");

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	// Clears fell when vsync stays high past the limit
	task automatic wait_vsync_fall(input int limit, output logic fell);
		int cycles;
		cycles = 0;
		@(negedge dclk);
		while (!vs_fall && cycles < limit) begin
			cycles++;
			@(negedge dclk);
		end
		fell = vs_fall;
		if (!fell)
			$display("t=%0t vsync did not fall within %0d cycles", $time, limit);
	endtask

	initial begin
		logic vs_ok;
		dclk = 1'b0;
		clr = 1'b1;
		vs_ok = 1'b1;
		repeat (RESET_CYCLES) @(posedge dclk);
		clr <= 1'b0;
		for (int f = 0; f < VSYNC_FALLS && vs_ok; f++)
			wait_vsync_fall(FALL_TIMEOUT, vs_ok);
		if (vs_ok) begin
			// Let the last frame check settle
			repeat (4) @(posedge dclk);
			$display("all tests passed");
			$finish;
		end else begin
			$display("tests failed");
			$fatal(1, "timeout waiting for vsync");
		end
	end

endmodule

//--- common/title_pkg.sv
package title_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Raster timing, 640x480 at 25 MHz
	////////////////////////////////////////////////////////////////////////////

	localparam int CNT_W = 10;
	// Clocks per line and lines per frame
	localparam int H_TOTAL = 800;
	localparam int V_TOTAL = 521;
	// Sync pulse lengths, both active low
	localparam int H_PULSE = 96;
	localparam int V_PULSE = 2;
	// Active window, 784 - 144 = 640 wide, 511 - 31 = 480 high
	localparam int H_BP = 144;
	localparam int H_FP = 784;
	localparam int V_BP = 31;
	localparam int V_FP = 511;

	// Colour word is RRR_GGG_BB
	localparam int COLOUR_W = 8;
	localparam logic [COLOUR_W-1:0] COLOUR_BLACK = 8'b000_000_00;
	localparam logic [COLOUR_W-1:0] COLOUR_WHITE = 8'b111_111_11;
	localparam logic [COLOUR_W-1:0] COLOUR_GREEN = 8'b000_111_00;

	////////////////////////////////////////////////////////////////////////////
	// Glyph tables
	////////////////////////////////////////////////////////////////////////////

	// Rectangle word is {x_lo, x_hi, y_lo, y_hi}
	// Half-open bounds, active-area coordinates
	localparam int RECT_W = 4 * CNT_W;
	localparam int ROW_W = 2;
	localparam int GLYPH_W = 4;

	localparam int NUM_ROWS = 3;
	localparam int NUM_GLYPHS = 14;
	localparam int NUM_CUTS = 77;

	// Packs four bounds into one rectangle word
	function automatic logic [RECT_W-1:0] rect(
		input int x_lo,
		input int x_hi,
		input int y_lo,
		input int y_hi
	);
		return {CNT_W'(x_lo), CNT_W'(x_hi), CNT_W'(y_lo), CNT_W'(y_hi)};
	endfunction

	// Point test, low bound in and high bound out
	function automatic logic in_rect(
		input logic [RECT_W-1:0] r,
		input logic [CNT_W-1:0] x,
		input logic [CNT_W-1:0] y
	);
		logic [CNT_W-1:0] x_lo;
		logic [CNT_W-1:0] x_hi;
		logic [CNT_W-1:0] y_lo;
		logic [CNT_W-1:0] y_hi;
		x_lo = r[4*CNT_W-1 -: CNT_W];
		x_hi = r[3*CNT_W-1 -: CNT_W];
		y_lo = r[2*CNT_W-1 -: CNT_W];
		y_hi = r[CNT_W-1 -: CNT_W];
		return (x >= x_lo) && (x < x_hi) && (y >= y_lo) && (y < y_hi);
	endfunction

	// Glyphs 0-4 SPACE, 5-12 INVADERS, 13 the enemy sprite
	localparam logic [RECT_W-1:0] GLYPH_BOX [NUM_GLYPHS] = '{
		rect(201, 240, 101, 150), rect(251, 290, 101, 150), rect(301, 340, 101, 150),
		rect(351, 390, 101, 150), rect(401, 440, 101, 150),
		rect(186, 215, 191, 230), rect(221, 250, 191, 230), rect(256, 285, 191, 230),
		rect(291, 320, 191, 230), rect(326, 355, 191, 230), rect(361, 390, 191, 230),
		rect(396, 425, 191, 230), rect(431, 460, 191, 230),
		rect(291, 350, 271, 350)
	};

	localparam logic [ROW_W-1:0] GLYPH_ROW [NUM_GLYPHS] = '{
		2'd0, 2'd0, 2'd0, 2'd0, 2'd0,
		2'd1, 2'd1, 2'd1, 2'd1, 2'd1, 2'd1, 2'd1, 2'd1,
		2'd2
	};

	localparam logic [COLOUR_W-1:0] ROW_COLOUR [NUM_ROWS] = '{
		COLOUR_WHITE, COLOUR_GREEN, COLOUR_WHITE
	};

	// Cut-outs, grouped by owning glyph
	localparam logic [RECT_W-1:0] CUT_RECT [NUM_CUTS] = '{
		// S
		rect(201, 210, 101, 105), rect(231, 240, 101, 105), rect(211, 230, 111, 120),
		rect(230, 240, 115, 125), rect(201, 210, 126, 135), rect(210, 230, 131, 140),
		rect(201, 210, 146, 150), rect(231, 240, 146, 150),
		// P
		rect(286, 290, 101, 105), rect(261, 280, 106, 120), rect(286, 290, 121, 125),
		rect(261, 290, 125, 150),
		// A
		rect(301, 305, 101, 105), rect(336, 340, 101, 105), rect(311, 330, 106, 120),
		rect(311, 330, 126, 150),
		// C
		rect(351, 360, 101, 105), rect(381, 390, 101, 105), rect(361, 380, 111, 140),
		rect(380, 390, 116, 135), rect(351, 360, 146, 150), rect(381, 390, 146, 150),
		// E
		rect(411, 440, 111, 120), rect(431, 440, 120, 130), rect(411, 440, 130, 140),
		// I
		rect(186, 195, 196, 225), rect(206, 215, 196, 225),
		// N, stepped diagonal
		rect(231, 240, 191, 195), rect(234, 240, 195, 200), rect(237, 240, 200, 205),
		rect(231, 233, 216, 220), rect(231, 236, 220, 225), rect(231, 240, 225, 230),
		// V
		rect(266, 275, 191, 210), rect(256, 260, 216, 225), rect(281, 285, 216, 225),
		rect(256, 265, 225, 230), rect(276, 285, 225, 230),
		// A
		rect(291, 295, 191, 195), rect(316, 320, 191, 195), rect(301, 310, 196, 205),
		rect(301, 310, 211, 230),
		// D
		rect(346, 355, 191, 195), rect(351, 355, 195, 200), rect(346, 355, 225, 230),
		rect(351, 355, 221, 225), rect(336, 340, 196, 225), rect(340, 345, 201, 220),
		// E
		rect(371, 390, 196, 205), rect(381, 390, 205, 215), rect(371, 390, 215, 225),
		// R
		rect(421, 425, 191, 195), rect(406, 415, 196, 205), rect(421, 425, 206, 215),
		rect(406, 410, 211, 215), rect(406, 415, 215, 230),
		// S
		rect(431, 435, 191, 195), rect(456, 460, 191, 195), rect(436, 456, 201, 207),
		rect(435, 455, 214, 220), rect(456, 460, 203, 210), rect(431, 435, 210, 218),
		rect(431, 435, 226, 230), rect(456, 460, 226, 230),
		// Sprite, antennae down to feet
		rect(291, 310, 271, 280), rect(331, 350, 271, 280), rect(291, 300, 280, 290),
		rect(341, 350, 280, 290), rect(306, 315, 291, 300), rect(326, 335, 291, 300),
		rect(291, 305, 311, 320), rect(336, 350, 311, 320), rect(291, 300, 320, 330),
		rect(311, 315, 320, 330), rect(326, 330, 320, 330), rect(341, 350, 320, 330),
		rect(301, 340, 341, 350)
	};

	// Owner of each cut-out, same order as CUT_RECT
	localparam logic [GLYPH_W-1:0] CUT_GLYPH [NUM_CUTS] = '{
		4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0,
		4'd1, 4'd1, 4'd1, 4'd1,
		4'd2, 4'd2, 4'd2, 4'd2,
		4'd3, 4'd3, 4'd3, 4'd3, 4'd3, 4'd3,
		4'd4, 4'd4, 4'd4,
		4'd5, 4'd5,
		4'd6, 4'd6, 4'd6, 4'd6, 4'd6, 4'd6,
		4'd7, 4'd7, 4'd7, 4'd7, 4'd7,
		4'd8, 4'd8, 4'd8, 4'd8,
		4'd9, 4'd9, 4'd9, 4'd9, 4'd9, 4'd9,
		4'd10, 4'd10, 4'd10,
		4'd11, 4'd11, 4'd11, 4'd11, 4'd11,
		4'd12, 4'd12, 4'd12, 4'd12, 4'd12, 4'd12, 4'd12, 4'd12,
		4'd13, 4'd13, 4'd13, 4'd13, 4'd13, 4'd13, 4'd13,
		4'd13, 4'd13, 4'd13, 4'd13, 4'd13, 4'd13
	};

endpackage

//--- list.f
common/title_pkg.sv
timing/raster_timing.sv
render/glyph_row.sv
render/title_renderer.sv
logic/vga_title_top.sv
bench/title_tb.sv

//--- logic/vga_title_top.sv
module vga_title_top (
	input  logic dclk,
	input  logic clr,
	output logic hsync,
	output logic vsync,
	output logic [title_pkg::COLOUR_W-1:0] colour
);
	import title_pkg::*;

	// Raster position and flags
	logic [CNT_W-1:0] pos_x;
	logic [CNT_W-1:0] pos_y;
	logic active_x;
	logic active_y;
	// Unregistered sync levels
	logic hsync_raw;
	logic vsync_raw;

	raster_timing raster_timing_inst (
		.dclk(dclk),
		.clr(clr),
		.pos_x(pos_x),
		.pos_y(pos_y),
		.active_x(active_x),
		.active_y(active_y),
		.hsync_raw(hsync_raw),
		.vsync_raw(vsync_raw)
	);

	// Renderer owns the output register
	title_renderer title_renderer_inst (
		.dclk(dclk),
		.clr(clr),
		.pos_x(pos_x),
		.pos_y(pos_y),
		.active_x(active_x),
		.active_y(active_y),
		.hsync_raw(hsync_raw),
		.vsync_raw(vsync_raw),
		.hsync(hsync),
		.vsync(vsync),
		.colour(colour)
	);

endmodule

//--- render/glyph_row.sv
module glyph_row #(
	parameter int ROW = 0
) (
	input  logic [title_pkg::CNT_W-1:0] pos_x,
	input  logic [title_pkg::CNT_W-1:0] pos_y,
	output logic row_hit,
	output logic row_lit
);
	import title_pkg::*;

	// One bit per glyph of the whole table
	// Only glyphs of this row can set theirs
	logic [NUM_GLYPHS-1:0] box_hit;
	// Pixel falls in a cut-out of the matched glyph
	logic cut_hit;

	////////////////////////////////////////////////////////////////////////////
	// Box test
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		box_hit = '0;
		for (int g = 0; g < NUM_GLYPHS; g++) begin
			if (GLYPH_ROW[g] == ROW_W'(ROW))
				box_hit[g] = in_rect(GLYPH_BOX[g], pos_x, pos_y);
		end
	end

	// Boxes in a row never overlap, so at most one bit is set
	assign row_hit = |box_hit;

	////////////////////////////////////////////////////////////////////////////
	// Cut-out test
	////////////////////////////////////////////////////////////////////////////

	// A cut-out only counts when its owner's box holds the pixel
	// Cut-outs of other rows drop out through box_hit
	always_comb begin
		cut_hit = 1'b0;
		for (int c = 0; c < NUM_CUTS; c++) begin
			if (box_hit[CUT_GLYPH[c]] && in_rect(CUT_RECT[c], pos_x, pos_y))
				cut_hit = 1'b1;
		end
	end

	// Lit means glyph body, not hole
	assign row_lit = row_hit && !cut_hit;

endmodule

//--- render/title_renderer.sv
module title_renderer (
	input  logic dclk,
	input  logic clr,
	input  logic [title_pkg::CNT_W-1:0] pos_x,
	input  logic [title_pkg::CNT_W-1:0] pos_y,
	input  logic active_x,
	input  logic active_y,
	input  logic hsync_raw,
	input  logic vsync_raw,
	output logic hsync,
	output logic vsync,
	output logic [title_pkg::COLOUR_W-1:0] colour
);
	import title_pkg::*;

	// Per-row results from the glyph rows
	logic [NUM_ROWS-1:0] row_hit;
	logic [NUM_ROWS-1:0] row_lit;
	// Combinational pixel colour
	logic [COLOUR_W-1:0] colour_next;
	// Active flag, aligned with the colour register
	logic active_q;

	////////////////////////////////////////////////////////////////////////////
	// Glyph rows
	////////////////////////////////////////////////////////////////////////////

	// Row 0 SPACE, row 1 INVADERS, row 2 the sprite
	for (genvar r = 0; r < NUM_ROWS; r++) begin : gen_row
		glyph_row #(
			.ROW(r)
		) glyph_row_inst (
			.pos_x(pos_x),
			.pos_y(pos_y),
			.row_hit(row_hit[r]),
			.row_lit(row_lit[r])
		);
	end

	////////////////////////////////////////////////////////////////////////////
	// Colour select and output register
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		colour_next = COLOUR_BLACK;
		if (active_x && active_y) begin
			// Highest row first, so row 0 wins any tie
			for (int r = NUM_ROWS - 1; r >= 0; r--) begin
				if (row_lit[r])
					colour_next = ROW_COLOUR[r];
			end
		end
	end

	// Sync and colour leave together, one cycle after the counters
	always_ff @(posedge dclk or posedge clr) begin
		if (clr) begin
			hsync <= 1'b1;
			vsync <= 1'b1;
			colour <= COLOUR_BLACK;
			active_q <= 1'b0;
		end else begin
			hsync <= hsync_raw;
			vsync <= vsync_raw;
			colour <= colour_next;
			active_q <= active_x && active_y;
		end
	end

	// Blanking holds at the pins
	a_blank: assert property (
		@(posedge dclk) disable iff (clr)
		!active_q |-> (colour == COLOUR_BLACK)
	) else $error("colour not black outside active area");

	// Rows sit apart on screen, so row priority never decides a pixel
	a_rows_apart: assert property (
		@(posedge dclk) disable iff (clr)
		$onehot0(row_hit)
	) else $error("glyph boxes of two rows overlap");

endmodule

//--- timing/raster_timing.sv
module raster_timing (
	input  logic dclk,
	input  logic clr,
	output logic [title_pkg::CNT_W-1:0] pos_x,
	output logic [title_pkg::CNT_W-1:0] pos_y,
	output logic active_x,
	output logic active_y,
	output logic hsync_raw,
	output logic vsync_raw
);
	import title_pkg::*;

	// Raw column and line counters
	logic [CNT_W-1:0] col;
	logic [CNT_W-1:0] line;
	// Last column of the line
	logic col_wrap;

	assign col_wrap = (col == CNT_W'(H_TOTAL - 1));

	////////////////////////////////////////////////////////////////////////////
	// Counters
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge dclk or posedge clr) begin
		if (clr) begin
			col <= '0;
			line <= '0;
		end else begin
			if (col_wrap) begin
				col <= '0;
				// Frame wraps after line 520
				if (line == CNT_W'(V_TOTAL - 1))
					line <= '0;
				else
					line <= line + 1'b1;
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	// Sync low at the start of line and frame
	assign hsync_raw = (col >= CNT_W'(H_PULSE));
	assign vsync_raw = (line >= CNT_W'(V_PULSE));

	// Visible window
	assign active_x = (col >= CNT_W'(H_BP)) && (col < CNT_W'(H_FP));
	assign active_y = (line >= CNT_W'(V_BP)) && (line < CNT_W'(V_FP));

	// Position relative to the visible window
	// Wraps to large values in the porches, gated by the active flags
	assign pos_x = col - CNT_W'(H_BP);
	assign pos_y = line - CNT_W'(V_BP);

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	a_col_range: assert property (
		@(posedge dclk) disable iff (clr)
		col < CNT_W'(H_TOTAL)
	) else $error("column counter beyond line length");

	// Line moves only on the cycle after a column wrap
	a_line_step: assert property (
		@(posedge dclk) disable iff (clr)
		!col_wrap |=> (line == $past(line))
	) else $error("line counter moved mid-line");

endmodule
